//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath and address width
  localparam int unsigned word_w = 16;
  // register index width, sixteen registers
  localparam int unsigned reg_addr_w = 4;
  // opcode field width, instr[15:12]
  localparam int unsigned op_w = 4;
  // z, v and n flags
  localparam int unsigned flags_w = 3;

  // sequential pc increment, one 16-bit word
  localparam logic [word_w-1:0] pc_step = word_w'(2);

  // opcode map
  localparam logic [op_w-1:0] op_add = 4'd0;
  localparam logic [op_w-1:0] op_sub = 4'd1;
  localparam logic [op_w-1:0] op_xor = 4'd2;
  localparam logic [op_w-1:0] op_and = 4'd3;
  localparam logic [op_w-1:0] op_sll = 4'd4;
  localparam logic [op_w-1:0] op_sra = 4'd5;
  localparam logic [op_w-1:0] op_ror = 4'd6;
  localparam logic [op_w-1:0] op_or = 4'd7;
  localparam logic [op_w-1:0] op_lw = 4'd8;
  localparam logic [op_w-1:0] op_sw = 4'd9;
  localparam logic [op_w-1:0] op_llb = 4'd10;
  localparam logic [op_w-1:0] op_lhb = 4'd11;
  localparam logic [op_w-1:0] op_b = 4'd12;
  localparam logic [op_w-1:0] op_br = 4'd13;
  localparam logic [op_w-1:0] op_pcs = 4'd14;
  localparam logic [op_w-1:0] op_hlt = 4'd15;

  // bit positions inside the flag vector
  localparam int unsigned flag_z = 0;
  localparam int unsigned flag_v = 1;
  localparam int unsigned flag_n = 2;

  // write-back source select
  localparam logic [1:0] sel_alu = 2'd0;
  localparam logic [1:0] sel_mem = 2'd1;
  localparam logic [1:0] sel_pcs = 2'd2;

  // program rom geometry, word addressed
  localparam int unsigned rom_depth = 256;
  localparam int unsigned rom_addr_w = $clog2(rom_depth);
  // image loaded at elaboration
  localparam string rom_file = "program.hex";

endpackage

`default_nettype wire

//--- core/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [cpu_pkg::op_w-1:0]    op,
  input  logic [cpu_pkg::word_w-1:0]  a,
  input  logic [cpu_pkg::word_w-1:0]  b,
  output logic [cpu_pkg::word_w-1:0]  y,
  output logic [cpu_pkg::flags_w-1:0] flags_out
);
  import cpu_pkg::*;

  logic [word_w-1:0]   sum;
  logic [word_w-1:0]   diff;
  // doubled operand, shifting right gives the rotate
  logic [2*word_w-1:0] rot;
  logic                add_ovf;
  logic                sub_ovf;
  logic                ovf;

  // 16-bit wraparound, no carry out kept
  assign sum  = a + b;
  assign diff = a - b;

  // same-sign operands, result sign flipped
  assign add_ovf = (a[word_w-1] == b[word_w-1]) && (sum[word_w-1] != a[word_w-1]);
  // different-sign operands, result sign differs from a
  assign sub_ovf = (a[word_w-1] != b[word_w-1]) && (diff[word_w-1] != a[word_w-1]);

  assign rot = {a, a} >> b[3:0];

  always_comb begin
    y   = '0;
    ovf = 1'b0;
    case (op)
      op_add: begin
        y   = sum;
        ovf = add_ovf;
      end
      op_sub: begin
        y   = diff;
        ovf = sub_ovf;
      end
      op_xor: y = a ^ b;
      op_and: y = a & b;
      op_or:  y = a | b;
      // shift amount is the 4-bit immediate
      op_sll: y = a << b[3:0];
      op_sra: y = $signed(a) >>> b[3:0];
      op_ror: y = rot[word_w-1:0];
      // byte loads keep the other half of rd
      op_llb: y = {a[word_w-1:8], b[7:0]};
      op_lhb: y = {b[7:0], a[7:0]};
      default: y = '0;
    endcase
  end

  // z and n follow the result, v only meaningful for add and sub
  assign flags_out[flag_z] = (y == '0);
  assign flags_out[flag_v] = ovf;
  assign flags_out[flag_n] = y[word_w-1];

endmodule

`default_nettype wire

//--- core/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs,
  input  logic [cpu_pkg::reg_addr_w-1:0] rt,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd,
  input  logic                           we,
  input  logic [cpu_pkg::word_w-1:0]     wdata,
  output logic [cpu_pkg::word_w-1:0]     rs_data,
  output logic [cpu_pkg::word_w-1:0]     rt_data,
  input  logic                           flag_we,
  input  logic                           v_we,
  input  logic [cpu_pkg::flags_w-1:0]    flags_in,
  output logic [cpu_pkg::flags_w-1:0]    flags
);
  import cpu_pkg::*;

  logic [word_w-1:0] regs [2**reg_addr_w];

  // r0 is never written, so it reads back zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // plain combinational reads, a write shows up next cycle
  assign rs_data = regs[rs];
  assign rt_data = regs[rt];

  // z and n on every flag-setting op, v only on add and sub
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      if (flag_we) begin
        flags[flag_z] <= flags_in[flag_z];
        flags[flag_n] <= flags_in[flag_n];
      end
      if (v_we) begin
        flags[flag_v] <= flags_in[flag_v];
      end
    end
  end

endmodule

`default_nettype wire

//--- core/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  logic [cpu_pkg::word_w-1:0]     instr,
  output logic [cpu_pkg::reg_addr_w-1:0] rs,
  output logic [cpu_pkg::reg_addr_w-1:0] rt,
  output logic [cpu_pkg::reg_addr_w-1:0] rd,
  output logic                           reg_we,
  output logic [1:0]                     wb_sel,
  output logic [cpu_pkg::word_w-1:0]     alu_imm,
  output logic                           use_imm,
  output logic                           flag_we,
  output logic                           v_we,
  output logic                           mem_rd,
  output logic                           mem_wr,
  output logic                           hlt
);
  import cpu_pkg::*;

  logic [op_w-1:0] opcode;
  logic            is_alu;
  logic            is_shift;
  logic            is_byte;

  assign opcode = instr[15:12];

  // opcodes 0..7 are the register/shift compute group
  assign is_alu   = ~opcode[3];
  assign is_shift = (opcode == op_sll) || (opcode == op_sra) || (opcode == op_ror);
  assign is_byte  = (opcode == op_llb) || (opcode == op_lhb);

  // destination always sits in 11:8, lw included
  assign rd = instr[11:8];
  // byte loads read back their own destination
  assign rs = is_byte ? instr[11:8] : instr[7:4];
  // store data register shares the rd field
  assign rt = (opcode == op_sw) ? instr[11:8] : instr[3:0];

  // shift amount is 4 bits, byte immediate is 8
  assign use_imm = is_shift | is_byte;
  assign alu_imm = is_byte ? {{(word_w-8){1'b0}}, instr[7:0]}
                           : {{(word_w-4){1'b0}}, instr[3:0]};

  assign reg_we = is_alu | is_byte | (opcode == op_lw) | (opcode == op_pcs);

  always_comb begin
    case (opcode)
      op_lw:   wb_sel = sel_mem;
      op_pcs:  wb_sel = sel_pcs;
      default: wb_sel = sel_alu;
    endcase
  end

  // byte loads leave the flags alone
  assign flag_we = is_alu;
  assign v_we    = (opcode == op_add) || (opcode == op_sub);

  assign mem_rd = (opcode == op_lw);
  assign mem_wr = (opcode == op_sw);
  assign hlt    = (opcode == op_hlt);

endmodule

`default_nettype wire

//--- core/pc_control.sv
`timescale 1ns/1ps
`default_nettype none

module pc_control (
  input  logic [cpu_pkg::word_w-1:0]  pc,
  input  logic [cpu_pkg::word_w-1:0]  instr,
  input  logic [cpu_pkg::flags_w-1:0] flags,
  input  logic [cpu_pkg::word_w-1:0]  rs_data,
  output logic [cpu_pkg::word_w-1:0]  next_pc
);
  import cpu_pkg::*;

  logic [op_w-1:0]   opcode;
  logic [2:0]        cond;
  logic              cond_met;
  logic [word_w-1:0] pc_inc;
  logic [word_w-1:0] br_off;

  assign opcode = instr[15:12];
  assign cond   = instr[11:9];
  assign pc_inc = pc + pc_step;

  // 9-bit word offset, sign extended and made a byte offset
  assign br_off = {{(word_w-10){instr[8]}}, instr[8:0], 1'b0};

  always_comb begin
    case (cond)
      3'b000: cond_met = ~flags[flag_z];
      3'b001: cond_met = flags[flag_z];
      // greater than
      3'b010: cond_met = ~flags[flag_z] & ~flags[flag_n];
      3'b011: cond_met = flags[flag_n];
      3'b100: cond_met = flags[flag_z] | (~flags[flag_z] & ~flags[flag_n]);
      3'b101: cond_met = flags[flag_z] | flags[flag_n];
      3'b110: cond_met = flags[flag_v];
      default: cond_met = 1'b1;
    endcase
  end

  always_comb begin
    case (opcode)
      op_b:    next_pc = cond_met ? (pc_inc + br_off) : pc_inc;
      // register target used as-is
      op_br:   next_pc = cond_met ? rs_data : pc_inc;
      // halt parks the pc on itself
      op_hlt:  next_pc = pc;
      default: next_pc = pc_inc;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic                       mem_rd,
  input  logic                       mem_wr,
  input  logic [cpu_pkg::word_w-1:0] base,
  input  logic [3:0]                 offset,
  input  logic [cpu_pkg::word_w-1:0] store_data,
  input  logic                       ack,
  output logic                       cyc,
  output logic                       stb,
  output logic                       we,
  output logic [cpu_pkg::word_w-1:0] adr,
  output logic [cpu_pkg::word_w-1:0] dat_w,
  output logic                       stall
);
  import cpu_pkg::*;

  logic              req;
  logic [word_w-1:0] base_aligned;
  logic [word_w-1:0] offset_ext;
  logic [word_w-1:0] eff_addr;

  // the request follows the instruction at the pc
  // pc is frozen while stalled, so every line below holds steady
  // until the slave acks
  assign req = mem_rd | mem_wr;

  // word aligned base register
  assign base_aligned = {base[word_w-1:1], 1'b0};
  // 4-bit signed word offset, scaled to bytes
  assign offset_ext = {{(word_w-5){offset[3]}}, offset, 1'b0};
  assign eff_addr   = base_aligned + offset_ext;

  // classic cycle, cyc and stb rise together
  assign cyc = req;
  assign stb = req;
  assign we  = mem_wr;

  // address and write data parked at zero when idle
  assign adr   = req ? eff_addr : '0;
  assign dat_w = mem_wr ? store_data : '0;

  // ack in the same cycle ends the transfer on this edge
  // back-to-back accesses keep stb high into the next one
  assign stall = stb & ~ack;

endmodule

`default_nettype wire

//--- rtl/prog_rom.sv
`timescale 1ns/1ps
`default_nettype none

module prog_rom (
  input  logic                       clk,
  input  logic [cpu_pkg::word_w-1:0] addr,
  output logic [cpu_pkg::word_w-1:0] instr
);
  import cpu_pkg::*;

  // clk reserved for a registered read later on
  logic [word_w-1:0] rom [rom_depth];

  initial begin
    $readmemh(rom_file, rom);
  end

  // byte pc, drop bit 0 to get the word index
  assign instr = rom[addr[rom_addr_w:1]];

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       hlt,
  output logic [cpu_pkg::word_w-1:0] pc,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [cpu_pkg::word_w-1:0] wb_adr,
  output logic [cpu_pkg::word_w-1:0] wb_dat_w,
  input  logic [cpu_pkg::word_w-1:0] wb_dat_r,
  input  logic                       wb_ack
);
  import cpu_pkg::*;

  logic [word_w-1:0]     instr;
  logic [word_w-1:0]     next_pc;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [reg_addr_w-1:0] rd;
  logic                  reg_we;
  logic [1:0]            wb_sel;
  logic [word_w-1:0]     alu_imm;
  logic                  use_imm;
  logic                  flag_we;
  logic                  v_we;
  logic                  mem_rd;
  logic                  mem_wr;
  logic [word_w-1:0]     rs_data;
  logic [word_w-1:0]     rt_data;
  logic [word_w-1:0]     alu_b;
  logic [word_w-1:0]     alu_y;
  logic [flags_w-1:0]    alu_flags;
  logic [flags_w-1:0]    flags;
  logic [word_w-1:0]     wdata;
  logic                  stall;

  // pc only moves once any bus transfer has been acked
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= next_pc;
    end
  end

  prog_rom u_rom (
    .clk   (clk),
    .addr  (pc),
    .instr (instr)
  );

  decoder u_dec (
    .instr   (instr),
    .rs      (rs),
    .rt      (rt),
    .rd      (rd),
    .reg_we  (reg_we),
    .wb_sel  (wb_sel),
    .alu_imm (alu_imm),
    .use_imm (use_imm),
    .flag_we (flag_we),
    .v_we    (v_we),
    .mem_rd  (mem_rd),
    .mem_wr  (mem_wr),
    .hlt     (hlt)
  );

  // write-back source, pcs takes pc+2 which is next_pc for that op
  always_comb begin
    case (wb_sel)
      sel_mem: wdata = wb_dat_r;
      sel_pcs: wdata = next_pc;
      default: wdata = alu_y;
    endcase
  end

  // held-off writes while a load waits on ack
  register_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs       (rs),
    .rt       (rt),
    .rd       (rd),
    .we       (reg_we & ~stall),
    .wdata    (wdata),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .flag_we  (flag_we),
    .v_we     (v_we),
    .flags_in (alu_flags),
    .flags    (flags)
  );

  assign alu_b = use_imm ? alu_imm : rt_data;

  alu u_alu (
    .op        (instr[15:12]),
    .a         (rs_data),
    .b         (alu_b),
    .y         (alu_y),
    .flags_out (alu_flags)
  );

  pc_control u_pcc (
    .pc      (pc),
    .instr   (instr),
    .flags   (flags),
    .rs_data (rs_data),
    .next_pc (next_pc)
  );

  // no bus request while the core sits in reset
  lsu u_lsu (
    .mem_rd     (mem_rd & ~rst),
    .mem_wr     (mem_wr & ~rst),
    .base       (rs_data),
    .offset     (instr[3:0]),
    .store_data (rt_data),
    .ack        (wb_ack),
    .cyc        (wb_cyc),
    .stb        (wb_stb),
    .we         (wb_we),
    .adr        (wb_adr),
    .dat_w      (wb_dat_w),
    .stall      (stall)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);
  // 20 ns period
  localparam time half_period = 10ns;
  localparam int  rst_cycles  = 4;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // reset released on the edge after the last held cycle
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
  input wire        clk,
  input wire        rst,
  input wire        hlt,
  input wire [15:0] pc,
  input wire        wb_cyc,
  input wire        wb_stb,
  input wire        wb_we,
  input wire [15:0] wb_adr,
  input wire [15:0] wb_dat_w,
  input wire        wb_ack
);

  // a strobe is only valid inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("wishbone stb high without cyc");

  // request lines frozen until the slave acks
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
    else $error("wishbone request changed while waiting for ack");

  // halted core keeps its pc and stays halted
  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    hlt |=> (hlt && $stable(pc)))
    else $error("pc moved after halt");

endmodule

bind cpu cpu_chk u_chk (.*);

`default_nettype wire

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam int prog_len      = 55;
  localparam int max_ack_delay = 3;
  localparam int timeout_cycles = 40 * prog_len + max_ack_delay;
  localparam int halt_cycles   = 20;

  logic        clk;
  logic        rst;
  logic        hlt;
  logic [15:0] pc;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r = 16'h0000;
  logic        wb_ack = 1'b0;

  // slave model state
  logic [15:0] mem [64];
  logic [1:0]  wait_cnt = 2'd0;
  integer      seed = 32'h8ef8;
  // address in the upper half, data in the lower half
  logic [31:0] bus_writes [$];

  // reference model state
  logic [15:0] ref_rom [rom_depth];
  logic [15:0] ref_mem [64];
  logic [15:0] ref_regs [16];
  logic [15:0] ref_pc;
  logic        ref_z;
  logic        ref_v;
  logic        ref_n;
  int          ref_count;
  logic        exp_store;
  logic [15:0] exp_adr;
  logic [15:0] exp_dat;

  int          errors = 0;
  int          checks = 0;
  int          dut_count = 0;
  int          store_count = 0;
  logic [15:0] prev_pc = 16'h0000;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  cpu DUT (
    .clk      (clk),
    .rst      (rst),
    .hlt      (hlt),
    .pc       (pc),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  // preload pattern that depends on every address bit
  function automatic logic [15:0] fill_word(input int unsigned i);
    return 16'(i * 32'h0000_0b3d) ^ 16'h5a0f;
  endfunction

  task automatic value_mismatch(input string name, input logic [15:0] expv,
                                input logic [15:0] actv);
    $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expv, actv);
    errors++;
  endtask

  task automatic log_failure(input string what);
    $display("[FAIL] t=%0t %s", $time, what);
    errors++;
  endtask

  // one instruction of the ISA on the shadow state with zero-wait memory
  function automatic void iss_step();
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] y;
    logic [15:0] addr;
    logic [15:0] next;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic        wr;
    logic        cond_ok;
    ins  = ref_rom[ref_pc[rom_addr_w:1]];
    op   = ins[15:12];
    rd   = ins[11:8];
    a    = ref_regs[ins[7:4]];
    b    = ref_regs[ins[3:0]];
    y    = 16'h0000;
    wr   = 1'b0;
    next = ref_pc + 16'd2;
    exp_store = 1'b0;
    // even base plus a signed word offset counted in bytes
    addr = (a & ~16'h0001) + 16'(2 * $signed(ins[3:0]));
    case (ins[11:9])
      3'd0: cond_ok = !ref_z;
      3'd1: cond_ok = ref_z;
      3'd2: cond_ok = !ref_z && !ref_n;
      3'd3: cond_ok = ref_n;
      3'd4: cond_ok = ref_z || !ref_n;
      3'd5: cond_ok = ref_z || ref_n;
      3'd6: cond_ok = ref_v;
      default: cond_ok = 1'b1;
    endcase
    case (op)
      op_add: begin
        y = a + b;
        ref_v = (a[15] == b[15]) && (y[15] != a[15]);
      end
      op_sub: begin
        y = a - b;
        ref_v = (a[15] != b[15]) && (y[15] != a[15]);
      end
      op_xor: y = a ^ b;
      op_and: y = a & b;
      op_or:  y = a | b;
      op_sll: y = a << ins[3:0];
      op_sra: y = $signed(a) >>> ins[3:0];
      op_ror: y = (a >> ins[3:0]) | (a << (5'd16 - {1'b0, ins[3:0]}));
      op_lw: begin
        y  = ref_mem[addr[6:1]];
        wr = 1'b1;
      end
      op_sw: begin
        exp_store = 1'b1;
        exp_adr   = addr;
        exp_dat   = ref_regs[rd];
        ref_mem[addr[6:1]] = ref_regs[rd];
      end
      op_llb: begin
        y  = {ref_regs[rd][15:8], ins[7:0]};
        wr = 1'b1;
      end
      op_lhb: begin
        y  = {ins[7:0], ref_regs[rd][7:0]};
        wr = 1'b1;
      end
      // 9-bit signed word offset from the following instruction
      op_b:   if (cond_ok) next = ref_pc + 16'd2 + 16'(2 * $signed(ins[8:0]));
      op_br:  if (cond_ok) next = a;
      op_pcs: begin
        y  = ref_pc + 16'd2;
        wr = 1'b1;
      end
      default: next = ref_pc;
    endcase
    // compute group sets z and n and writes rd
    if (!op[3]) begin
      wr    = 1'b1;
      ref_z = (y == 16'h0000);
      ref_n = y[15];
    end
    if (wr && rd != 4'd0) ref_regs[rd] = y;
    ref_pc = next;
    ref_count++;
  endfunction

  initial begin
    $readmemh(rom_file, ref_rom);
    for (int i = 0; i < 64; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 16; i++) ref_regs[i] = 16'h0000;
    ref_pc    = 16'h0000;
    ref_z     = 1'b0;
    ref_v     = 1'b0;
    ref_n     = 1'b0;
    ref_count = 0;
  end

  // wishbone slave with random 0..3 wait cycles per transfer
  always @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wait_cnt <= 2'($random(seed));
    end else if (wb_ack) begin
      // this edge ends the transfer while the master still drives it
      wb_ack <= 1'b0;
      if (wb_we) begin
        mem[wb_adr[6:1]] <= wb_dat_w;
        bus_writes.push_back({wb_adr, wb_dat_w});
      end
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt == 2'd0) begin
        wb_ack   <= 1'b1;
        wb_dat_r <= mem[wb_adr[6:1]];
        wait_cnt <= 2'($random(seed));
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  // step the reference on each retirement and compare
  always @(negedge clk) begin
    logic [31:0] seen;
    if (!rst && pc != prev_pc) begin
      iss_step();
      checks++;
      if (pc != ref_pc) value_mismatch("pc", ref_pc, pc);
      if (exp_store) begin
        store_count++;
        checks++;
        if (bus_writes.size() == 0) begin
          log_failure("store retired without a bus write");
        end else begin
          seen = bus_writes.pop_front();
          if (seen[31:16] != exp_adr) value_mismatch("wb_adr", exp_adr, seen[31:16]);
          if (seen[15:0] != exp_dat) value_mismatch("wb_dat_w", exp_dat, seen[15:0]);
        end
      end
    end
    prev_pc = pc;
    // the next rising edge retires one instruction unless a transfer waits for ack
    if (!rst && !hlt && !(wb_stb && !wb_ack)) begin
      dut_count++;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: core did not halt within %0d cycles", timeout_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int          start_err;
    logic [15:0] held_pc;
    // reset values while held and just after release
    start_err = errors;
    @(negedge clk);
    while (rst) begin
      checks++;
      if (pc != 16'h0000) value_mismatch("pc", 16'h0000, pc);
      if (wb_cyc || wb_stb || hlt) log_failure("bus or halt active during reset");
      @(negedge clk);
    end
    if (pc != 16'h0000) value_mismatch("pc", 16'h0000, pc);
    if (wb_cyc || wb_stb || hlt) log_failure("bus or halt active after reset");
    $display("test reset: %0d errors", errors - start_err);

    // run the program until the core parks on hlt
    start_err = errors;
    wait (hlt);
    repeat (2) @(negedge clk);
    if (ref_rom[ref_pc[rom_addr_w:1]][15:12] != op_hlt) begin
      log_failure("reference did not reach halt with the core");
    end
    if (dut_count != ref_count) log_failure("retired count differs from reference");
    $display("test program trace: %0d retired, %0d errors", dut_count, errors - start_err);

    // stores retired and bus writes must pair up exactly
    if (bus_writes.size() != 0) log_failure("extra bus writes seen");
    $display("test bus writes: %0d stores checked", store_count);

    // pc parked and hlt held
    start_err = errors;
    held_pc = pc;
    repeat (halt_cycles) begin
      @(negedge clk);
      checks++;
      if (!hlt) log_failure("hlt dropped after halt");
      if (pc != held_pc) value_mismatch("pc", held_pc, pc);
    end
    $display("test halt: %0d errors", errors - start_err);

    $display("checks %0d, errors %0d, retired %0d", checks, errors, dut_count);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wisc_cpu.f
common/cpu_pkg.sv
core/alu.sv
core/register_file.sv
core/decoder.sv
core/pc_control.sv
rtl/lsu.sv
rtl/prog_rom.sv
rtl/cpu.sv
testbench/tb_clock.sv
testbench/cpu_chk.sv
testbench/tb_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the tb_cpu simulation with Verilator.
set -u

cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert --top-module tb_cpu -f wisc_cpu.f -o Vtb_cpu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# the ROM image is opened by its bare name, so run next to it
(cd testbench && ../obj_dir/Vtb_cpu) > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$log"; then
  exit 1
fi
if ! grep -q '\*\*\* TEST PASSED \*\*\*' "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

//--- testbench/program.hex
// one 16-bit instruction word per line, from word address 0
// opcode in the first digit, operand fields after it
A120 // r1 = 0x0020 store base
A27F
B27F
A301
0422 // add with signed overflow
9410
1534
9511
2623
3724
7834
4944
5A45
6B43
9612
9713
9814
9915
9A16
9B17
8C1F // loads at negative offsets
8D1E
0ECD
9E1C
2FFF // z set
C001
AD11
C201
AD22
C601
AD33
1F03 // n set
C401
AD44
CA01
AD55
CC01
AD66
0F22 // v set
CC01
AD77
0F33 // greater
C801
AD88
C001
AD99
CE01
ADAA
9D18
EE00 // pcs
AF6A
DEF0 // br always to 0x6a
AD00
9E1A
F000
